//--- Makefile
VERILATOR ?= verilator
TOP       ?= periph_tb
FILELIST  ?= src.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --assert -j 0
RUN_ARGS  ?= +verilator+error+limit+100
PASS_MSG  ?= ALL CHECKS PASSED

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	@out=$$(./$(OBJ_DIR)/V$(TOP) $(RUN_ARGS)); \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

lint:
	$(VERILATOR) --lint-only --timing --assert --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)

//--- hdl/periph_pkg.sv
// --------------------
// Shared types and constants of the peripheral block
// Byte address bits 7:6 pick the region, bits 5:2 the register word
// Source id 0 is reserved for "no interrupt"
// --------------------
package periph_pkg;

    localparam int DataWidth = 32;
    localparam int AddrWidth = 8;

    typedef logic [DataWidth-1:0] data_t;
    typedef logic [AddrWidth-1:0] addr_t;
    typedef logic [3:0]           offset_t;

    typedef enum logic [1:0] {
        RegionPlic  = 2'd0,
        RegionUart  = 2'd1,
        RegionTimer = 2'd2,
        RegionNone  = 2'd3
    } region_e;

    // Interrupt sources
    localparam int NumSources = 2;

    typedef logic [1:0] src_id_t;
    typedef logic [2:0] prio_t;

    localparam src_id_t SrcUart  = 2'd1;
    localparam src_id_t SrcTimer = 2'd2;

    // --------------------
    // Register word offsets
    // --------------------
    localparam offset_t PlicPrio1     = 4'd0;
    localparam offset_t PlicPrio2     = 4'd1;
    localparam offset_t PlicEnable    = 4'd2;
    localparam offset_t PlicThreshold = 4'd3;
    localparam offset_t PlicClaim     = 4'd4;

    localparam offset_t UartTxdata = 4'd0;
    localparam offset_t UartStatus = 4'd1;
    localparam offset_t UartIer    = 4'd2;

    localparam offset_t TimerCount = 4'd0;
    localparam offset_t TimerCmp   = 4'd1;
    localparam offset_t TimerCtrl  = 4'd2;

endpackage

//--- hdl/periph_top.sv
// --------------------
// Peripheral block with PLIC, UART TX and timer behind one register port
// Single host, one access per cycle, response always one cycle later
// --------------------
`timescale 1ns/10ps

module periph_top #(
    parameter int ClksPerBit = 8
) (
    input  logic              clk_i,
    input  logic              rst_i,
    // Host register port
    input  logic              req_i,
    input  logic              we_i,
    input  periph_pkg::addr_t addr_i,
    input  periph_pkg::data_t wdata_i,
    output periph_pkg::data_t rdata_o,
    output logic              ready_o,
    output logic              err_o,
    // Interrupt to the hart and serial line
    output logic              irq_o,
    output logic              tx_o
);

    reg_bus_if plic_bus ();
    reg_bus_if uart_bus ();
    reg_bus_if timer_bus ();

    logic src_uart;
    logic src_timer;

    reg_decoder i_reg_decoder (
        .clk_i       ( clk_i     ),
        .rst_i       ( rst_i     ),
        .req_i       ( req_i     ),
        .we_i        ( we_i      ),
        .addr_i      ( addr_i    ),
        .wdata_i     ( wdata_i   ),
        .rdata_o     ( rdata_o   ),
        .ready_o     ( ready_o   ),
        .err_o       ( err_o     ),
        .plic_bus_o  ( plic_bus  ),
        .uart_bus_o  ( uart_bus  ),
        .timer_bus_o ( timer_bus )
    );

    plic_core i_plic_core (
        .clk_i       ( clk_i     ),
        .rst_i       ( rst_i     ),
        .bus         ( plic_bus  ),
        .src_uart_i  ( src_uart  ),
        .src_timer_i ( src_timer ),
        .irq_o       ( irq_o     )
    );

    uart_tx #(
        .ClksPerBit ( ClksPerBit )
    ) i_uart_tx (
        .clk_i ( clk_i    ),
        .rst_i ( rst_i    ),
        .bus   ( uart_bus ),
        .irq_o ( src_uart ),
        .tx_o  ( tx_o     )
    );

    timer_cmp i_timer_cmp (
        .clk_i ( clk_i     ),
        .rst_i ( rst_i     ),
        .bus   ( timer_bus ),
        .irq_o ( src_timer )
    );

endmodule

//--- hdl/plic_core.sv
// --------------------
// Reduced PLIC, one target, level-triggered sources only
// ENABLE bit n enables source n, bit 0 unused
// A source must exceed THRESHOLD to interrupt or be claimed
// --------------------
`timescale 1ns/10ps

module plic_core (
    input  logic      clk_i,
    input  logic      rst_i,
    reg_bus_if.device bus,
    input  logic      src_uart_i,
    input  logic      src_timer_i,
    output logic      irq_o
);
    import periph_pkg::*;

    prio_t               prio_q [NumSources:1];
    prio_t               threshold_q;
    logic [NumSources:1] enable_q;
    logic [NumSources:1] pending_q;
    logic [NumSources:1] claimed_q;
    logic [NumSources:1] level;
    logic                irq_q;

    src_id_t best_id;
    prio_t   best_prio;
    src_id_t done_id;
    logic    claim_rd;
    data_t   rdata_d;

    assign level[SrcUart]  = src_uart_i;
    assign level[SrcTimer] = src_timer_i;

    // --------------------
    // Source arbitration
    // --------------------
    // Strict compare keeps the lower id on equal priority
    always_comb begin
        best_id   = '0;
        best_prio = '0;
        for (int i = 1; i <= NumSources; i++) begin
            if (pending_q[i] && enable_q[i] && (prio_q[i] > threshold_q) &&
                (best_id == '0 || prio_q[i] > best_prio)) begin
                best_id   = src_id_t'(i);
                best_prio = prio_q[i];
            end
        end
    end

    assign claim_rd = bus.req && !bus.we && (bus.offset == PlicClaim);
    assign done_id  = src_id_t'(bus.wdata);

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            for (int i = 1; i <= NumSources; i++) begin
                prio_q[i] <= '0;
            end
            threshold_q <= '0;
            enable_q    <= '0;
            pending_q   <= '0;
            claimed_q   <= '0;
            irq_q       <= 1'b0;
            bus.ready   <= 1'b0;
        end else begin
            // Gateway, a claimed source is held off until completion
            pending_q <= pending_q | (level & ~claimed_q);
            irq_q     <= (best_id != '0);
            bus.ready <= bus.req;

            if (bus.req && bus.we) begin
                case (bus.offset)
                    PlicPrio1:     prio_q[SrcUart]  <= prio_t'(bus.wdata);
                    PlicPrio2:     prio_q[SrcTimer] <= prio_t'(bus.wdata);
                    PlicEnable:    enable_q         <= bus.wdata[NumSources:1];
                    PlicThreshold: threshold_q      <= prio_t'(bus.wdata);
                    PlicClaim: begin
                        // Completion
                        if (done_id != '0 && int'(done_id) <= NumSources) begin
                            claimed_q[done_id] <= 1'b0;
                        end
                    end
                    default: ;
                endcase
            end

            if (claim_rd && best_id != '0) begin
                pending_q[best_id] <= 1'b0;
                claimed_q[best_id] <= 1'b1;
            end
        end
    end

    // Read data, unmapped words read 0
    always_comb begin
        case (bus.offset)
            PlicPrio1:     rdata_d = data_t'(prio_q[SrcUart]);
            PlicPrio2:     rdata_d = data_t'(prio_q[SrcTimer]);
            PlicEnable:    rdata_d = data_t'({enable_q, 1'b0});
            PlicThreshold: rdata_d = data_t'(threshold_q);
            PlicClaim:     rdata_d = data_t'(best_id);
            default:       rdata_d = '0;
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (bus.req) begin
            bus.rdata <= bus.we ? '0 : rdata_d;
        end
    end

    assign irq_o = irq_q;

endmodule

//--- hdl/reg_bus_if.sv
// --------------------
// Register port of one peripheral
// Device answers with ready one cycle after req, no stalls
// --------------------
`timescale 1ns/10ps

interface reg_bus_if;
    import periph_pkg::*;

    logic    req;
    logic    we;
    offset_t offset;
    data_t   wdata;
    data_t   rdata;
    logic    ready;

    modport host (
        output req, we, offset, wdata,
        input  rdata, ready
    );

    modport device (
        input  req, we, offset, wdata,
        output rdata, ready
    );

endinterface

//--- hdl/reg_decoder.sv
// --------------------
// Address decoder for the host register port
// Only whole-word accesses, byte lane bits 1:0 are ignored
// Region 3 is unmapped and gets an error response
// --------------------
`timescale 1ns/10ps

module reg_decoder (
    input  logic              clk_i,
    input  logic              rst_i,
    input  logic              req_i,
    input  logic              we_i,
    input  periph_pkg::addr_t addr_i,
    input  periph_pkg::data_t wdata_i,
    output periph_pkg::data_t rdata_o,
    output logic              ready_o,
    output logic              err_o,
    reg_bus_if.host           plic_bus_o,
    reg_bus_if.host           uart_bus_o,
    reg_bus_if.host           timer_bus_o
);
    import periph_pkg::*;

    region_e region;
    offset_t offset;
    logic    err_q;

    assign region = region_e'(addr_i[7:6]);
    assign offset = addr_i[5:2];

    // --------------------
    // Request forwarding
    // --------------------
    // Only the selected peripheral sees the strobe
    assign plic_bus_o.req    = req_i && (region == RegionPlic);
    assign plic_bus_o.we     = we_i;
    assign plic_bus_o.offset = offset;
    assign plic_bus_o.wdata  = wdata_i;

    assign uart_bus_o.req    = req_i && (region == RegionUart);
    assign uart_bus_o.we     = we_i;
    assign uart_bus_o.offset = offset;
    assign uart_bus_o.wdata  = wdata_i;

    assign timer_bus_o.req    = req_i && (region == RegionTimer);
    assign timer_bus_o.we     = we_i;
    assign timer_bus_o.offset = offset;
    assign timer_bus_o.wdata  = wdata_i;

    // Unmapped access answered here one cycle later
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            err_q <= 1'b0;
        end else begin
            err_q <= req_i && (region == RegionNone);
        end
    end

    // --------------------
    // Response merge
    // --------------------
    // At most one responder is ready in a cycle
    always_comb begin
        rdata_o = '0;
        if (plic_bus_o.ready) begin
            rdata_o = plic_bus_o.rdata;
        end else if (uart_bus_o.ready) begin
            rdata_o = uart_bus_o.rdata;
        end else if (timer_bus_o.ready) begin
            rdata_o = timer_bus_o.rdata;
        end
    end

    assign ready_o = plic_bus_o.ready | uart_bus_o.ready | timer_bus_o.ready | err_q;
    assign err_o   = err_q;

endmodule

//--- hdl/timer_cmp.sv
// --------------------
// Free-running 32-bit timer with compare interrupt
// Counter wraps silently, interrupt is a level, not a pulse
// --------------------
`timescale 1ns/10ps

module timer_cmp (
    input  logic      clk_i,
    input  logic      rst_i,
    reg_bus_if.device bus,
    output logic      irq_o
);
    import periph_pkg::*;

    data_t count_q;
    data_t cmp_q;
    logic  en_q;
    logic  wr;
    data_t rdata_d;

    assign wr = bus.req && bus.we;

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            count_q   <= '0;
            cmp_q     <= '0;
            en_q      <= 1'b0;
            bus.ready <= 1'b0;
        end else begin
            bus.ready <= bus.req;
            // Host write takes precedence over counting
            if (wr && bus.offset == TimerCount) begin
                count_q <= bus.wdata;
            end else if (en_q) begin
                count_q <= count_q + 1'b1;
            end
            if (wr && bus.offset == TimerCmp) begin
                cmp_q <= bus.wdata;
            end
            if (wr && bus.offset == TimerCtrl) begin
                en_q <= bus.wdata[0];
            end
        end
    end

    assign irq_o = en_q && (count_q >= cmp_q);

    // Read data
    always_comb begin
        case (bus.offset)
            TimerCount: rdata_d = count_q;
            TimerCmp:   rdata_d = cmp_q;
            TimerCtrl:  rdata_d = data_t'(en_q);
            default:    rdata_d = '0;
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (bus.req) begin
            bus.rdata <= bus.we ? '0 : rdata_d;
        end
    end

endmodule

//--- hdl/uart_tx.sv
// --------------------
// Transmit-only UART, 8N1, no FIFO
// A TXDATA write while busy is dropped
// --------------------
`timescale 1ns/10ps

module uart_tx #(
    parameter int ClksPerBit = 8
) (
    input  logic      clk_i,
    input  logic      rst_i,
    reg_bus_if.device bus,
    output logic      irq_o,
    output logic      tx_o
);
    import periph_pkg::*;

    localparam int CntWidth = (ClksPerBit > 1) ? $clog2(ClksPerBit) : 1;

    logic                busy_q;
    logic                ier_q;
    logic [9:0]          shift_q;
    logic [3:0]          bit_cnt_q;
    logic [CntWidth-1:0] baud_cnt_q;
    logic                bit_end;
    logic                start;
    data_t               rdata_d;

    assign start   = bus.req && bus.we && (bus.offset == UartTxdata) && !busy_q;
    assign bit_end = (baud_cnt_q == CntWidth'(ClksPerBit - 1));

    // --------------------
    // Frame sequencer
    // --------------------
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            busy_q     <= 1'b0;
            bit_cnt_q  <= '0;
            baud_cnt_q <= '0;
        end else if (start) begin
            busy_q     <= 1'b1;
            bit_cnt_q  <= '0;
            baud_cnt_q <= '0;
        end else if (busy_q) begin
            baud_cnt_q <= bit_end ? '0 : baud_cnt_q + 1'b1;
            if (bit_end) begin
                bit_cnt_q <= bit_cnt_q + 1'b1;
                // Stop bit done
                if (bit_cnt_q == 4'd9) begin
                    busy_q <= 1'b0;
                end
            end
        end
    end

    // Stop, data LSB first, start in bit 0
    always_ff @(posedge clk_i) begin
        if (start) begin
            shift_q <= {1'b1, bus.wdata[7:0], 1'b0};
        end else if (busy_q && bit_end) begin
            shift_q <= {1'b1, shift_q[9:1]};
        end
    end

    assign tx_o  = busy_q ? shift_q[0] : 1'b1;
    assign irq_o = ier_q && !busy_q;

    // --------------------
    // Register port
    // --------------------
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            ier_q     <= 1'b0;
            bus.ready <= 1'b0;
        end else begin
            bus.ready <= bus.req;
            if (bus.req && bus.we && bus.offset == UartIer) begin
                ier_q <= bus.wdata[0];
            end
        end
    end

    // TXDATA is write only
    always_comb begin
        case (bus.offset)
            UartStatus: rdata_d = data_t'(busy_q);
            UartIer:    rdata_d = data_t'(ier_q);
            default:    rdata_d = '0;
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (bus.req) begin
            bus.rdata <= bus.we ? '0 : rdata_d;
        end
    end

endmodule

//--- src.f
hdl/periph_pkg.sv
hdl/reg_bus_if.sv
hdl/reg_decoder.sv
hdl/plic_core.sv
hdl/uart_tx.sv
hdl/timer_cmp.sv
hdl/periph_top.sv
verification/periph_checker.sv
verification/periph_tb.sv

//--- verification/periph_checker.sv
// --------------------
// Concurrent assertions on the host port and reset state
// Bound into periph_top, failures are counted in fail_count
// --------------------
`timescale 1ns/10ps

module periph_checker (
    input logic              clk_i,
    input logic              rst_i,
    input logic              req_i,
    input periph_pkg::addr_t addr_i,
    input logic              ready_i,
    input logic              err_i,
    input logic              irq_i,
    input logic              tx_i
);
    import periph_pkg::*;

    int fail_count = 0;

    // Every request answered exactly one cycle later
    ready_after_req: assert property (@(posedge clk_i) disable iff (rst_i)
        req_i |=> ready_i)
        else begin
            $error("ready_o missing one cycle after req_i");
            fail_count++;
        end

    // No response without a request
    ready_has_req: assert property (@(posedge clk_i) disable iff (rst_i)
        ready_i |-> $past(req_i))
        else begin
            $error("ready_o without a request in the previous cycle");
            fail_count++;
        end

    // Error only as the answer to an unmapped request
    err_on_unmapped: assert property (@(posedge clk_i) disable iff (rst_i)
        err_i |-> (ready_i && $past(req_i && (addr_i[7:6] == RegionNone))))
        else begin
            $error("err_o raised without ready_o for an unmapped request");
            fail_count++;
        end

    // Outputs idle in the cycle after a reset cycle
    idle_after_reset: assert property (@(posedge clk_i)
        rst_i |=> (tx_i && !irq_i && !ready_i && !err_i))
        else begin
            $error("outputs not idle after reset");
            fail_count++;
        end

endmodule

//--- verification/periph_tb.sv
// --------------------
// Testbench for the peripheral block, run with ClksPerBit 8
// Inputs change on the rising edge, outputs are sampled on the falling edge
// Random values come from a 16-bit Fibonacci LFSR
// --------------------
`timescale 1ns/10ps

module periph_tb;
    import periph_pkg::*;

    localparam int ClksPerBit = 8;
    localparam int Timeout    = 200;

    logic  clk = 1'b0;
    logic  rst;
    logic  req;
    logic  we;
    addr_t addr;
    data_t wdata;
    data_t rdata;
    logic  ready;
    logic  err;
    logic  irq;
    logic  tx;

    logic [15:0] lfsr_q;
    string       test_name;
    int          tests;
    int          checks;
    int          errors;
    int          test_errors;

    periph_top #(
        .ClksPerBit ( ClksPerBit )
    ) periph_top_i (
        .clk_i   ( clk   ),
        .rst_i   ( rst   ),
        .req_i   ( req   ),
        .we_i    ( we    ),
        .addr_i  ( addr  ),
        .wdata_i ( wdata ),
        .rdata_o ( rdata ),
        .ready_o ( ready ),
        .err_o   ( err   ),
        .irq_o   ( irq   ),
        .tx_o    ( tx    )
    );

    bind periph_top periph_checker periph_checker_i (
        .clk_i   ( clk_i   ),
        .rst_i   ( rst_i   ),
        .req_i   ( req_i   ),
        .addr_i  ( addr_i  ),
        .ready_i ( ready_o ),
        .err_i   ( err_o   ),
        .irq_i   ( irq_o   ),
        .tx_i    ( tx_o    )
    );

    always #5 clk = ~clk;

    // --------------------
    // Helpers
    // --------------------
    // Taps 16, 14, 13, 11
    function automatic data_t get_random(input int nbits);
        logic  fb;
        data_t val;
        val = '0;
        for (int i = 0; i < nbits; i++) begin
            fb     = lfsr_q[0] ^ lfsr_q[2] ^ lfsr_q[3] ^ lfsr_q[5];
            lfsr_q = {fb, lfsr_q[15:1]};
            val    = {val[DataWidth-2:0], lfsr_q[0]};
        end
        return val;
    endfunction

    function automatic addr_t reg_addr(input region_e region, input offset_t offset);
        return {region, offset, 2'b00};
    endfunction

    // Highest priority above threshold wins, lower id on a tie
    function automatic src_id_t expected_claim(input prio_t p1, input prio_t p2,
                                               input logic [2:1] en, input prio_t thr,
                                               input logic [2:1] lvl);
        logic ok1;
        logic ok2;
        ok1 = en[1] && lvl[1] && (p1 > thr);
        ok2 = en[2] && lvl[2] && (p2 > thr);
        if (ok1 && ok2) begin
            return (p2 > p1) ? SrcTimer : SrcUart;
        end
        if (ok1) begin
            return SrcUart;
        end
        if (ok2) begin
            return SrcTimer;
        end
        return 2'd0;
    endfunction

    // Bit 0 is the start bit, bit 9 the stop bit
    function automatic logic [9:0] uart_frame(input logic [7:0] data);
        logic [9:0] frame;
        frame[0] = 1'b0;
        for (int i = 0; i < 8; i++) begin
            frame[i+1] = data[i];
        end
        frame[9] = 1'b1;
        return frame;
    endfunction

    task automatic report_timeout(input string why);
        errors++;
        test_errors++;
        $display("%s: timeout, %s", test_name, why);
    endtask

    task automatic check_data(input string name, input data_t exp, input data_t act);
        checks++;
        if (act !== exp) begin
            errors++;
            test_errors++;
            $display("FAILED %s %s: expected 0x%08h actual 0x%08h", test_name, name, exp, act);
        end
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        checks++;
        if (act !== exp) begin
            errors++;
            test_errors++;
            $display("FAILED %s %s: expected %b actual %b", test_name, name, exp, act);
        end
    endtask

    task automatic check_id(input string name, input src_id_t exp, input src_id_t act);
        checks++;
        if (act !== exp) begin
            errors++;
            test_errors++;
            $display("FAILED %s %s: expected %0d actual %0d", test_name, name, exp, act);
        end
    endtask

    task automatic start_case(input string name);
        test_name   = name;
        test_errors = 0;
    endtask

    task automatic finish_case();
        tests++;
        $display("test %0d %s: %s", tests, test_name, (test_errors == 0) ? "ok" : "mismatch");
    endtask

    // --------------------
    // Bus and wait tasks
    // --------------------
    task automatic bus_access(input logic wr, input addr_t a, input data_t wd,
                              output data_t rd, output logic e);
        int waited;
        @(posedge clk);
        req   <= 1'b1;
        we    <= wr;
        addr  <= a;
        wdata <= wd;
        @(posedge clk);
        req   <= 1'b0;
        waited = 0;
        @(negedge clk);
        while (ready !== 1'b1 && waited < Timeout) begin
            @(negedge clk);
            waited++;
        end
        if (ready !== 1'b1) begin
            report_timeout("ready_o never answered a bus access");
        end
        rd = rdata;
        e  = err;
    endtask

    task automatic write_reg(input addr_t a, input data_t wd);
        data_t rd;
        logic  e;
        bus_access(1'b1, a, wd, rd, e);
    endtask

    task automatic read_reg(input addr_t a, output data_t rd);
        logic e;
        bus_access(1'b0, a, '0, rd, e);
    endtask

    // Returns the irq_o level seen when the wait ends
    task automatic wait_irq(input logic level, output logic seen);
        int waited;
        waited = 0;
        @(negedge clk);
        while (irq !== level && waited < Timeout) begin
            @(negedge clk);
            waited++;
        end
        seen = irq;
    endtask

    // --------------------
    // Tests
    // --------------------
    task automatic readback_regs();
        data_t r1;
        data_t r2;
        data_t r3;
        data_t r4;
        data_t rd;
        start_case("readback");
        r1 = get_random(32);
        r2 = get_random(32);
        r3 = get_random(32);
        r4 = get_random(32);
        write_reg(reg_addr(RegionPlic, PlicPrio1), r1);
        write_reg(reg_addr(RegionPlic, PlicPrio2), r2);
        write_reg(reg_addr(RegionPlic, PlicThreshold), r3);
        write_reg(reg_addr(RegionTimer, TimerCmp), r4);
        read_reg(reg_addr(RegionPlic, PlicPrio1), rd);
        check_data("prio1", r1 & 32'h7, rd);
        read_reg(reg_addr(RegionPlic, PlicPrio2), rd);
        check_data("prio2", r2 & 32'h7, rd);
        read_reg(reg_addr(RegionPlic, PlicThreshold), rd);
        check_data("threshold", r3 & 32'h7, rd);
        read_reg(reg_addr(RegionTimer, TimerCmp), rd);
        check_data("cmp", r4, rd);
        finish_case();
    endtask

    task automatic unmapped_access();
        data_t wd;
        data_t rd;
        logic  e;
        start_case("unmapped");
        wd = get_random(32);
        bus_access(1'b1, reg_addr(RegionNone, 4'd0), wd, rd, e);
        check_bit("write err", 1'b1, e);
        check_data("write rdata", '0, rd);
        bus_access(1'b0, reg_addr(RegionNone, 4'd3), '0, rd, e);
        check_bit("read err", 1'b1, e);
        check_data("read rdata", '0, rd);
        bus_access(1'b0, reg_addr(RegionTimer, TimerCmp), '0, rd, e);
        check_bit("mapped err", 1'b0, e);
        finish_case();
    endtask

    task automatic uart_frame_tx();
        data_t      r;
        data_t      rd;
        logic [7:0] tx_byte;
        logic [9:0] rx;
        int         waited;
        start_case("uart");
        r = get_random(8);
        tx_byte = r[7:0];
        write_reg(reg_addr(RegionUart, UartTxdata), data_t'(tx_byte));
        waited = 0;
        while (tx === 1'b1 && waited < Timeout) begin
            @(negedge clk);
            waited++;
        end
        if (tx !== 1'b0) begin
            report_timeout("tx_o never showed a start bit");
        end
        // Move to the middle of the start bit, then one sample per bit period
        repeat (ClksPerBit / 2) @(negedge clk);
        rx[0] = tx;
        for (int i = 1; i < 10; i++) begin
            repeat (ClksPerBit) @(negedge clk);
            rx[i] = tx;
        end
        check_data("frame", data_t'(uart_frame(tx_byte)), data_t'(rx));
        // Still inside the stop bit
        read_reg(reg_addr(RegionUart, UartStatus), rd);
        check_bit("busy in frame", 1'b1, rd[0]);
        waited = 0;
        while (rd[0] === 1'b1 && waited < 20) begin
            read_reg(reg_addr(RegionUart, UartStatus), rd);
            waited++;
        end
        check_bit("busy after frame", 1'b0, rd[0]);
        finish_case();
    endtask

    task automatic timer_interrupt();
        data_t rd;
        logic  seen;
        start_case("timer irq");
        write_reg(reg_addr(RegionPlic, PlicThreshold), 32'd1);
        write_reg(reg_addr(RegionPlic, PlicPrio1), 32'd0);
        write_reg(reg_addr(RegionPlic, PlicPrio2), 32'd3);
        write_reg(reg_addr(RegionPlic, PlicEnable), 32'h4);
        write_reg(reg_addr(RegionTimer, TimerCount), 32'd0);
        write_reg(reg_addr(RegionTimer, TimerCmp), 32'd6);
        write_reg(reg_addr(RegionTimer, TimerCtrl), 32'd1);
        wait_irq(1'b1, seen);
        check_bit("irq raised", 1'b1, seen);
        read_reg(reg_addr(RegionPlic, PlicClaim), rd);
        check_id("claim", SrcTimer, rd[1:0]);
        write_reg(reg_addr(RegionTimer, TimerCtrl), 32'd0);
        write_reg(reg_addr(RegionPlic, PlicClaim), data_t'(SrcTimer));
        wait_irq(1'b0, seen);
        check_bit("irq dropped", 1'b0, seen);
        finish_case();
    endtask

    task automatic priority_threshold();
        data_t   r;
        data_t   rd;
        prio_t   p1;
        prio_t   p2;
        src_id_t exp;
        logic    seen;
        logic    irq_seen;
        start_case("priority");
        r  = get_random(3);
        p1 = prio_t'(r);
        r  = get_random(3);
        p2 = prio_t'(r);
        write_reg(reg_addr(RegionPlic, PlicThreshold), 32'd0);
        write_reg(reg_addr(RegionPlic, PlicPrio1), data_t'(p1));
        write_reg(reg_addr(RegionPlic, PlicPrio2), data_t'(p2));
        write_reg(reg_addr(RegionPlic, PlicEnable), 32'h6);
        write_reg(reg_addr(RegionUart, UartIer), 32'd1);
        write_reg(reg_addr(RegionTimer, TimerCount), 32'd0);
        write_reg(reg_addr(RegionTimer, TimerCmp), 32'd0);
        write_reg(reg_addr(RegionTimer, TimerCtrl), 32'd1);
        exp = expected_claim(p1, p2, 2'b11, 3'd0, 2'b11);
        wait_irq(exp != 2'd0, seen);
        check_bit("irq both", exp != 2'd0, seen);
        read_reg(reg_addr(RegionPlic, PlicClaim), rd);
        check_id("claim both", exp, rd[1:0]);

        // Both priorities at or below the threshold
        write_reg(reg_addr(RegionPlic, PlicThreshold), 32'd5);
        r  = get_random(3);
        p1 = prio_t'(r % 32'd6);
        r  = get_random(3);
        p2 = prio_t'(r % 32'd6);
        write_reg(reg_addr(RegionPlic, PlicPrio1), data_t'(p1));
        write_reg(reg_addr(RegionPlic, PlicPrio2), data_t'(p2));
        write_reg(reg_addr(RegionPlic, PlicClaim), data_t'(SrcUart));
        write_reg(reg_addr(RegionPlic, PlicClaim), data_t'(SrcTimer));
        exp = expected_claim(p1, p2, 2'b11, 3'd5, 2'b11);
        irq_seen = 1'b0;
        repeat (4 * ClksPerBit) begin
            @(negedge clk);
            irq_seen |= irq;
        end
        check_bit("irq below threshold", 1'b0, irq_seen);
        read_reg(reg_addr(RegionPlic, PlicClaim), rd);
        check_id("claim below threshold", exp, rd[1:0]);
        finish_case();
    endtask

    // --------------------
    // Sequence
    // --------------------
    initial begin
        lfsr_q      = 16'd5368;
        tests       = 0;
        checks      = 0;
        errors      = 0;
        test_errors = 0;
        rst   <= 1'b1;
        req   <= 1'b0;
        we    <= 1'b0;
        addr  <= '0;
        wdata <= '0;
        repeat (4) @(posedge clk);
        rst <= 1'b0;
        @(posedge clk);

        readback_regs();
        unmapped_access();
        uart_frame_tx();
        timer_interrupt();
        priority_threshold();

        errors += periph_top_i.periph_checker_i.fail_count;
        $display("summary: %0d tests, %0d checks, %0d errors", tests, checks, errors);
        if (errors == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule
